// File: core_pkg.sv
// shared widths, opcode and operation enums, host address map
`default_nettype none

package core_pkg;

    // default sizes, overridden from the top level
    parameter int xlen_p       = 64;
    parameter int imem_bytes_p = 256;
    parameter int dmem_words_p = 32;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    // decoded operation, one per supported instruction
    typedef enum logic [2:0] {
        alu_add,
        alu_addi,
        mem_ld,
        mem_sd,
        br_eq,
        illegal
    } op_e;

    // host address map, 12-bit byte addresses
    localparam logic [11:0] imem_base   = 12'h000;
    localparam logic [11:0] ctrl_addr   = 12'h100;
    localparam logic [11:0] status_addr = 12'h104;
    // register i: low word at +8i, high word at +8i+4
    localparam logic [11:0] reg_base    = 12'h200;

endpackage

`default_nettype wire

// File: insmem.sv
// byte-wide instruction memory with word write port and little-endian fetch
`default_nettype none

module insmem #(
    parameter int imem_bytes = core_pkg::imem_bytes_p
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          imem_we,
    input  logic [$clog2(imem_bytes)-1:0] imem_waddr,
    input  logic [31:0]                   imem_wdata,
    input  logic [$clog2(imem_bytes)-1:0] pc,
    output logic [31:0]                   instruction,
    output core_pkg::opcode_e             opcode,
    output logic [4:0]                    rd,
    output logic [4:0]                    rs1,
    output logic [4:0]                    rs2
);

    import core_pkg::*;

    localparam int aw = $clog2(imem_bytes);

    logic [7:0]    mem [imem_bytes];
    logic [aw-1:0] waddr_1;
    logic [aw-1:0] waddr_2;
    logic [aw-1:0] waddr_3;
    logic [aw-1:0] faddr_1;
    logic [aw-1:0] faddr_2;
    logic [aw-1:0] faddr_3;

    // byte lanes wrap at the end of the array
    assign waddr_1 = imem_waddr + aw'(1);
    assign waddr_2 = imem_waddr + aw'(2);
    assign waddr_3 = imem_waddr + aw'(3);

    assign faddr_1 = pc + aw'(1);
    assign faddr_2 = pc + aw'(2);
    assign faddr_3 = pc + aw'(3);

    // cleared memory fetches zero words, which decode as illegal
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < imem_bytes; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (imem_we) begin
            // least significant byte at the lowest address
            mem[imem_waddr] <= imem_wdata[7:0];
            mem[waddr_1]    <= imem_wdata[15:8];
            mem[waddr_2]    <= imem_wdata[23:16];
            mem[waddr_3]    <= imem_wdata[31:24];
        end
    end

    assign instruction = {mem[faddr_3], mem[faddr_2], mem[faddr_1], mem[pc]};

    // funct3 and funct7 are not decoded
    assign opcode = opcode_e'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];

endmodule

`default_nettype wire

// File: inst_decode.sv
// opcode to operation mapping and immediate extraction with sign extension
`default_nettype none

module inst_decode #(
    parameter int xlen = core_pkg::xlen_p
) (
    input  logic [31:0]       instruction,
    input  core_pkg::opcode_e opcode,
    output core_pkg::op_e     op,
    output logic [xlen-1:0]   imm
);

    import core_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;

    // I layout for addi and ld
    assign imm_i = {{(xlen-12){instruction[31]}}, instruction[31:20]};

    // S layout for sd
    assign imm_s = {{(xlen-12){instruction[31]}}, instruction[31:25], instruction[11:7]};

    // B layout, offset in bytes so bit 0 is always zero
    assign imm_b = {{(xlen-13){instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};

    always_comb begin
        op  = illegal;
        imm = '0;
        case (opcode)
            op_reg: begin
                op = alu_add;
            end
            op_imm: begin
                op  = alu_addi;
                imm = imm_i;
            end
            op_load: begin
                op  = mem_ld;
                imm = imm_i;
            end
            op_store: begin
                op  = mem_sd;
                imm = imm_s;
            end
            op_branch: begin
                op  = br_eq;
                imm = imm_b;
            end
            // anything else halts the core
            default: op = illegal;
        endcase
    end

endmodule

`default_nettype wire

// File: regfile.sv
// 32-entry integer register file with two execute reads and one host read
`default_nettype none

module regfile #(
    parameter int xlen = core_pkg::xlen_p
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      host_raddr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    output logic [xlen-1:0] host_rdata,
    input  logic            wb_en,
    input  logic [4:0]      wb_addr,
    input  logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] regs [32];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != 5'd0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign rs1_data   = regs[rs1];
    assign rs2_data   = regs[rs2];
    assign host_rdata = regs[host_raddr];

endmodule

`default_nettype wire

// File: core_exec.sv
// program counter, adder, branch compare, data memory, writeback and halt
`default_nettype none

module core_exec #(
    parameter int xlen       = core_pkg::xlen_p,
    parameter int imem_bytes = core_pkg::imem_bytes_p,
    parameter int dmem_words = core_pkg::dmem_words_p
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          run,
    input  core_pkg::op_e                 op,
    input  logic [xlen-1:0]               imm,
    input  logic [4:0]                    rd,
    input  logic [xlen-1:0]               rs1_data,
    input  logic [xlen-1:0]               rs2_data,
    output logic [$clog2(imem_bytes)-1:0] pc,
    output logic                          wb_en,
    output logic [4:0]                    wb_addr,
    output logic [xlen-1:0]               wb_data,
    output logic                          halted
);

    import core_pkg::*;

    localparam int pc_w = $clog2(imem_bytes);
    localparam int dm_w = $clog2(dmem_words);

    logic [xlen-1:0] dmem [dmem_words];
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] ld_data;
    logic [dm_w-1:0] dm_addr;
    logic [pc_w-1:0] pc_next;
    logic            step;
    logic            taken;

    // one instruction retires per cycle while running and not halted
    assign step = run && !halted;

    // one adder serves add, addi and the ld/sd address
    assign alu_b = (op == alu_add) ? rs2_data : imm;
    assign sum   = rs1_data + alu_b;

    // doubleword index, wraps modulo dmem_words
    assign dm_addr = sum[dm_w+2:3];
    assign ld_data = dmem[dm_addr];

    assign taken   = (op == br_eq) && (rs1_data == rs2_data);
    assign pc_next = taken ? (pc + imm[pc_w-1:0]) : (pc + pc_w'(4));

    assign wb_en   = step && ((op == alu_add) || (op == alu_addi) || (op == mem_ld));
    assign wb_addr = rd;
    assign wb_data = (op == mem_ld) ? ld_data : sum;

    // pc freezes on an illegal op, halted holds until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (step) begin
            if (op == illegal) begin
                halted <= 1'b1;
            end else begin
                pc <= pc_next;
            end
        end
    end

    // store lands at the same edge as any register write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (step && (op == mem_sd)) begin
            dmem[dm_addr] <= rs2_data;
        end
    end

endmodule

`default_nettype wire

// File: axil_host_port.sv
// AXI4-Lite slave for program load, run control, status and register readback
`default_nettype none

module axil_host_port #(
    parameter int imem_bytes = core_pkg::imem_bytes_p
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [11:0]                   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [11:0]                   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          imem_we,
    output logic [$clog2(imem_bytes)-1:0] imem_waddr,
    output logic [31:0]                   imem_wdata,
    output logic                          run,
    input  logic                          halted,
    output logic [4:0]                    host_raddr,
    input  logic [63:0]                   host_rdata
);

    import core_pkg::*;

    localparam int aw = $clog2(imem_bytes);

    logic        wr_fire;
    logic        rd_fire;
    logic        imem_sel;
    logic [31:0] rd_mux;

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    // every access completes with OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    assign imem_sel   = (awaddr - imem_base) < imem_bytes;
    // program words only, partial strobes are ignored
    assign imem_we    = wr_fire && imem_sel && (&wstrb);
    assign imem_waddr = {awaddr[aw-1:2], 2'b00};
    assign imem_wdata = wdata;

    // write channel: one-cycle ready pulse, then the response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            run     <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire && (awaddr == ctrl_addr) && wstrb[0]) begin
                run <= wdata[0];
            end
        end
    end

    // register half select, low word first
    assign host_raddr = araddr[7:3];

    always_comb begin
        rd_mux = 32'h0;
        if (araddr[11:8] == reg_base[11:8]) begin
            rd_mux = araddr[2] ? host_rdata[63:32] : host_rdata[31:0];
        end else if (araddr == status_addr) begin
            rd_mux = {31'h0, halted};
        end else if (araddr == ctrl_addr) begin
            rd_mux = {31'h0, run};
        end
    end

    // read channel: data captured at address accept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_fire) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: rv_sub_top.sv
// top level: host port, instruction memory, decoder, register file, execute unit
`default_nettype none

module rv_sub_top #(
    parameter int xlen       = core_pkg::xlen_p,
    parameter int imem_bytes = core_pkg::imem_bytes_p,
    parameter int dmem_words = core_pkg::dmem_words_p
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    import core_pkg::*;

    localparam int aw = $clog2(imem_bytes);

    logic            imem_we;
    logic [aw-1:0]   imem_waddr;
    logic [31:0]     imem_wdata;
    logic            run;
    logic            halted;
    logic [4:0]      host_raddr;
    logic [xlen-1:0] host_rdata;
    logic [aw-1:0]   pc;
    logic [31:0]     instruction;
    opcode_e         opcode;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    op_e             op;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            wb_en;
    logic [4:0]      wb_addr;
    logic [xlen-1:0] wb_data;

    axil_host_port #(
        .imem_bytes(imem_bytes)
    ) axil_host_port_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .run        (run),
        .halted     (halted),
        .host_raddr (host_raddr),
        .host_rdata (host_rdata)
    );

    insmem #(
        .imem_bytes(imem_bytes)
    ) insmem_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_we     (imem_we),
        .imem_waddr  (imem_waddr),
        .imem_wdata  (imem_wdata),
        .pc          (pc),
        .instruction (instruction),
        .opcode      (opcode),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2)
    );

    inst_decode #(
        .xlen(xlen)
    ) inst_decode_inst (
        .instruction (instruction),
        .opcode      (opcode),
        .op          (op),
        .imm         (imm)
    );

    regfile #(
        .xlen(xlen)
    ) regfile_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .host_raddr (host_raddr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .host_rdata (host_rdata),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    core_exec #(
        .xlen       (xlen),
        .imem_bytes (imem_bytes),
        .dmem_words (dmem_words)
    ) core_exec_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .run      (run),
        .op       (op),
        .imm      (imm),
        .rd       (rd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .halted   (halted)
    );

endmodule

`default_nettype wire

// File: tb_rv_sub.sv
// testbench with program table, AXI4-Lite host tasks, result checks and watchdog
`default_nettype none

module tb_rv_sub;

    import core_pkg::*;

    localparam int num_rows = 10;
    localparam int clk_period = 20;
    // custom-0 opcode outside the subset
    localparam logic [31:0] ill_word = 32'h0000_000b;

    logic        clk;
    logic        arst_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // program table of words, register to read back and expected value
    logic [31:0] prog [num_rows][8];
    logic [4:0]  chk_reg [num_rows];
    logic [63:0] expect_val [num_rows];

    int mismatch_count;
    int protocol_count;

    rv_sub_top rv_sub_top_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // instruction encoders using RV64I field layouts
    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] add_word(input int rd, input int rs1, input int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] ld_word(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sd_word(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b011, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                7'b1100011};
    endfunction

    task automatic load_table();
        // x2 = 5 + 7 and x3 = x1 + x2
        prog[0] = '{addi_word(1, 0, 5), addi_word(2, 1, 7), add_word(3, 1, 2), ill_word,
                    ill_word, ill_word, ill_word, ill_word};
        chk_reg[0] = 5'd3;
        expect_val[0] = 64'd17;
        // negative immediate sign-extended
        prog[1] = '{addi_word(1, 0, -3), addi_word(2, 1, 1), ill_word, ill_word,
                    ill_word, ill_word, ill_word, ill_word};
        chk_reg[1] = 5'd2;
        expect_val[1] = 64'hffff_ffff_ffff_fffe;
        // 100 + (-200)
        prog[2] = '{addi_word(1, 0, 100), addi_word(2, 0, -200), add_word(5, 1, 2), ill_word,
                    ill_word, ill_word, ill_word, ill_word};
        chk_reg[2] = 5'd5;
        expect_val[2] = 64'hffff_ffff_ffff_ff9c;
        // store and load through the same base and offset
        prog[3] = '{addi_word(1, 0, -1234), addi_word(2, 0, 16), sd_word(1, 2, 8),
                    ld_word(3, 2, 8), ill_word, ill_word, ill_word, ill_word};
        chk_reg[3] = 5'd3;
        expect_val[3] = 64'hffff_ffff_ffff_fb2e;
        // 16 + 8 and 0 + 24 reach the same doubleword
        prog[4] = '{addi_word(1, 0, 2047), addi_word(2, 0, 16), sd_word(1, 2, 8),
                    ld_word(6, 0, 24), ill_word, ill_word, ill_word, ill_word};
        chk_reg[4] = 5'd6;
        expect_val[4] = 64'h0000_0000_0000_07ff;
        // equal operands so the branch skips the first addi to x7
        prog[5] = '{addi_word(1, 0, 9), addi_word(2, 0, 9), beq_word(1, 2, 8),
                    addi_word(7, 0, 1), addi_word(7, 7, 2), ill_word, ill_word, ill_word};
        chk_reg[5] = 5'd7;
        expect_val[5] = 64'd2;
        // unequal operands fall through
        prog[6] = '{addi_word(1, 0, 9), addi_word(2, 0, 8), beq_word(1, 2, 8),
                    addi_word(7, 0, 1), addi_word(7, 7, 2), ill_word, ill_word, ill_word};
        chk_reg[6] = 5'd7;
        expect_val[6] = 64'd3;
        prog[7] = '{addi_word(0, 0, 5), ill_word, ill_word, ill_word,
                    ill_word, ill_word, ill_word, ill_word};
        chk_reg[7] = 5'd0;
        expect_val[7] = 64'd0;
        // x9 is written only after the halt
        prog[8] = '{addi_word(8, 0, 4), ill_word, addi_word(9, 0, 5), ill_word,
                    ill_word, ill_word, ill_word, ill_word};
        chk_reg[8] = 5'd9;
        expect_val[8] = 64'd0;
        // 1 doubled six times
        prog[9] = '{addi_word(1, 0, 1), add_word(1, 1, 1), add_word(1, 1, 1),
                    add_word(1, 1, 1), add_word(1, 1, 1), add_word(1, 1, 1),
                    add_word(1, 1, 1), ill_word};
        chk_reg[9] = 5'd1;
        expect_val[9] = 64'd64;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    task automatic write_bus(input logic [11:0] addr, input logic [31:0] data);
        int unsigned gap;
        gap = $urandom_range(3, 0);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        assert (wready) else begin
            protocol_count++;
            $display("write data was not accepted together with the address, addr %h", addr);
        end
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        assert (bvalid) else begin
            protocol_count++;
            $display("write response did not follow the address accept, addr %h", addr);
        end
        // hold off bready to stall the response
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        assert (bresp == 2'b00) else begin
            protocol_count++;
            $display("write response was not OKAY, addr %h", addr);
        end
        @(posedge clk);
        #2;
        bready = 1'b0;
        @(negedge clk);
        assert (!bvalid) else begin
            protocol_count++;
            $display("write to %h got more than one response", addr);
        end
    endtask

    task automatic read_bus(input logic [11:0] addr, output logic [31:0] data);
        int unsigned gap;
        gap = $urandom_range(3, 0);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        assert (rvalid) else begin
            protocol_count++;
            $display("read data did not follow the address accept, addr %h", addr);
        end
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        assert (rresp == 2'b00) else begin
            protocol_count++;
            $display("read response was not OKAY, addr %h", addr);
        end
        @(posedge clk);
        #2;
        rready = 1'b0;
        @(negedge clk);
        assert (!rvalid) else begin
            protocol_count++;
            $display("read of %h got more than one response", addr);
        end
    endtask

    task automatic run_row(input int row);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] status;
        logic [11:0] addr;
        int          polls;
        reset_dut();
        for (int i = 0; i < 8; i++) begin
            write_bus(imem_base + 12'(4 * i), prog[row][i]);
        end
        write_bus(ctrl_addr, 32'h1);
        status = 32'h0;
        polls  = 0;
        while (!status[0] && polls < 50) begin
            read_bus(status_addr, status);
            polls++;
        end
        assert (status == 32'h1) else begin
            protocol_count++;
            $display("row %0d: core never reported halted, status %h", row, status);
        end
        addr = reg_base + 12'(8 * chk_reg[row]);
        read_bus(addr, lo);
        read_bus(addr + 12'd4, hi);
        assert ({hi, lo} == expect_val[row]) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: row %0d x%0d read %h, expected %h", $time, row,
                     chk_reg[row], {hi, lo}, expect_val[row]);
        end
    endtask

    // watchdog allows 400 cycles per table row
    initial begin
        #(num_rows * 400 * clk_period);
        $display("timeout: the test did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] word;
        void'($urandom(88));
        arst_n  = 1'b0;
        awaddr  = 12'h0;
        awvalid = 1'b0;
        wdata   = 32'h0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = 12'h0;
        arvalid = 1'b0;
        rready  = 1'b0;
        mismatch_count = 0;
        protocol_count = 0;
        load_table();
        for (int row = 0; row < num_rows; row++) begin
            run_row(row);
        end
        // unmapped address reads as zero
        read_bus(12'h180, word);
        assert (word == 32'h0) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: unmapped read returned %h", $time, word);
        end
        $display("errors: %0d mismatch, %0d protocol", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
core_pkg.sv
insmem.sv
inst_decode.sv
regfile.sv
core_exec.sv
axil_host_port.sv
rv_sub_top.sv
tb_rv_sub.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rv_sub -o sim_rv_sub
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_rv_sub)
sim_status=$?
echo "$out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
